// File: list.f
+incdir+include
hw/csr_pkg.sv
hw/csr_trap_if.sv
hw/csr_cycle_counter.sv
hw/csr_trap_fsm.sv
hw/csr_regfile.sv
hw/csr_unit_top.sv
verification/csr_unit_tb_sva.sv
verification/csr_unit_tb.sv

// File: Makefile
# Verilator build and run of the CSR unit testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module csr_unit_tb -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then \
	  echo "Simulation reported errors, see sim.log"; exit 1; \
	elif ! grep -q "Test completed successfully" sim.log; then \
	  echo "Simulation ended without a result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verification/csr_unit_tb.sv
/*
  Testbench for the CSR unit: clock and reset, directed
  and random CSR operations, exceptions, interrupts and
  mret, a reference model of the CSR state and per-cycle
  compare tasks for csr_rd_o and trap_o
*/
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb
  import csr_pkg::*;
();

  localparam rdata_t MTVEC_RESET = 32'h0000_0400;
  localparam int     RANDOM_OPS  = 200;
  // Directed sections need well under 160 cycles
  localparam int     STIM_CYCLES = RANDOM_OPS + 160;
  localparam int     TIMEOUT     = 2 * STIM_CYCLES + 100;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      stall;
  csr_op_e   op;
  csr_addr_e addr;
  rdata_t    rs1;
  imm_t      imm;
  logic      ext_irq, sw_irq, timer_irq;
  logic      illegal, will_jump, fetch_fault, ecall, ebreak, mret;
  pc_t       pc, illegal_pc;
  rdata_t    csr_rd;
  trap_t     trap;

  integer seed      = 77;
  int     cycles    = 0;
  int     word_errs = 0;
  int     trap_errs = 0;

  // Reference model state
  rdata_t     m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;
  logic [2:0] m_irq;  // {ext, sw, timer} as sampled last cycle
  logic       m_in_handler;
  cycle_t     m_count;
  trap_t      m_trap;

  csr_addr_e addr_pool [12];

  csr_unit_top #(
    .MTVEC_RESET (MTVEC_RESET)
  ) csr_unit_top_i (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .stall_i       (stall),
    .csr_op_i      (op),
    .csr_addr_i    (addr),
    .rs1_i         (rs1),
    .imm_i         (imm),
    .ext_irq_i     (ext_irq),
    .sw_irq_i      (sw_irq),
    .timer_irq_i   (timer_irq),
    .illegal_i     (illegal),
    .illegal_pc_i  (illegal_pc),
    .will_jump_i   (will_jump),
    .fetch_fault_i (fetch_fault),
    .ecall_i       (ecall),
    .ebreak_i      (ebreak),
    .mret_i        (mret),
    .pc_i          (pc),
    .csr_rd_o      (csr_rd),
    .trap_o        (trap)
  );

  always #5 clk = ~clk;

  // Expected read word for the current model state
  function automatic rdata_t model_csr(csr_addr_e a);
    case (a)
      CSR_MSTATUS:  return m_mstatus;
      CSR_MISA:     return 32'h4000_0100;
      CSR_MIE:      return m_mie;
      CSR_MTVEC:    return m_mtvec;
      CSR_MSCRATCH: return m_mscratch;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      CSR_MIP:      return {20'b0, m_irq[2], 3'b0, m_irq[0], 3'b0, m_irq[1], 3'b0};
      CSR_CYCLE:    return m_count[31:0];
      CSR_CYCLEH:   return m_count[63:32];
      default:      return '0;
    endcase
  endfunction

  function automatic rdata_t merge_write(csr_op_e o, rdata_t old, rdata_t src, rdata_t mask);
    rdata_t nv;

    if (o == CSR_RW || o == CSR_RWI) begin
      nv = src;
    end else if (o == CSR_RS || o == CSR_RSI) begin
      nv = old | src;
    end else begin
      nv = old & ~src;
    end
    return (nv & mask) | (old & ~mask);
  endfunction

  task automatic model_reset();
    m_mstatus    = '0;
    m_mie        = '0;
    m_mtvec      = MTVEC_RESET;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_irq        = '0;
    m_in_handler = 1'b0;
    m_count      = '0;
    m_trap       = '0;
  endtask

  // Advance the model by one clock, using the inputs the DUT samples next
  task automatic model_step();
    logic   ie, take, ret;
    rdata_t cause, epc, src, old_st, base;

    ie     = m_mstatus[3];
    old_st = m_mstatus;
    take   = 1'b1;
    epc    = pc;
    cause  = '0;
    if (ext_irq && ie && m_mie[11]) begin
      cause = 32'h8000_000B;
    end else if (sw_irq && ie && m_mie[3]) begin
      cause = 32'h8000_0003;
    end else if (timer_irq && ie && m_mie[7]) begin
      cause = 32'h8000_0007;
    end else if (!stall && illegal && !will_jump) begin
      cause = 32'd2;
      epc   = illegal_pc;
    end else if (!stall && fetch_fault) begin
      cause = 32'd1;
    end else if (!stall && ecall) begin
      cause = 32'd11;
    end else if (!stall && ebreak) begin
      cause = 32'd3;
    end else begin
      take = 1'b0;
    end
    ret = mret && !stall && m_in_handler && !take;

    base   = m_mtvec & 32'hFFFF_FFFC;
    m_trap = '0;
    if (take) begin
      m_trap.active = 1'b1;
      m_trap.target = (m_mtvec[0] && cause[31]) ? base + ((cause & 32'h7FFF_FFFF) << 2) : base;
    end else if (ret) begin
      m_trap.active = 1'b1;
      m_trap.target = m_mepc;
    end

    src = (op == CSR_RWI || op == CSR_RSI || op == CSR_RCI) ? imm : rs1;
    if (op != CSR_NONE && !stall && !take) begin
      case (addr)
        CSR_MSTATUS:  m_mstatus  = merge_write(op, m_mstatus, src, 32'h0000_0088);
        CSR_MIE:      m_mie      = merge_write(op, m_mie, src, 32'h0000_0888);
        CSR_MTVEC:    m_mtvec    = merge_write(op, m_mtvec, src, 32'hFFFF_FFFD);
        CSR_MSCRATCH: m_mscratch = merge_write(op, m_mscratch, src, 32'hFFFF_FFFF);
        CSR_MEPC:     m_mepc     = merge_write(op, m_mepc, src, 32'hFFFF_FFFC);
        default: ;
      endcase
    end

    if (take) begin
      m_mstatus[7] = ie;
      m_mstatus[3] = 1'b0;
      m_mepc       = epc & 32'hFFFF_FFFC;
      m_mcause     = cause;
      m_in_handler = 1'b1;
    end else if (ret) begin
      m_mstatus[3] = old_st[7];
      m_mstatus[7] = 1'b1;
      m_in_handler = 1'b0;
    end
    m_irq   = {ext_irq, sw_irq, timer_irq};
    m_count = m_count + 64'd1;
  endtask

  task automatic check_word(input string name, input rdata_t got, input rdata_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // Target only matters while the redirect is active
  task automatic check_trap(input string name, input trap_t got, input trap_t exp);
    if (got.active !== exp.active || (exp.active && got.target !== exp.target)) begin
      trap_errs++;
      $display("[FAIL] %s got 0x%09h expected 0x%09h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      check_word("csr_rd_o", csr_rd, model_csr(addr));
      check_trap("trap_o", trap, m_trap);
      model_step();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("Timeout: stimulus still running after %0d cycles", TIMEOUT);
      $display("Test failed");
      $finish;
    end
  end

  task automatic quiet_inputs();
    op          <= CSR_NONE;
    stall       <= 1'b0;
    illegal     <= 1'b0;
    will_jump   <= 1'b0;
    fetch_fault <= 1'b0;
    ecall       <= 1'b0;
    ebreak      <= 1'b0;
    mret        <= 1'b0;
  endtask

  task automatic cycle_csr(input csr_op_e o, input csr_addr_e a, input rdata_t r,
                           input imm_t i, input logic stl);
    @(posedge clk);
    op    <= o;
    addr  <= a;
    rs1   <= r;
    imm   <= i;
    stall <= stl;
  endtask

  // Exception bits are {ebreak, ecall, fetch_fault, illegal}, with a
  // mscratch write in the same cycle that a trap must cancel
  task automatic raise_sync(input logic [3:0] exc, input logic jump, input logic stl);
    @(posedge clk);
    illegal     <= exc[0];
    fetch_fault <= exc[1];
    ecall       <= exc[2];
    ebreak      <= exc[3];
    will_jump   <= jump;
    stall       <= stl;
    pc          <= $random(seed);
    illegal_pc  <= $random(seed);
    op          <= CSR_RW;
    addr        <= CSR_MSCRATCH;
    rs1         <= $random(seed);
    @(posedge clk);
    quiet_inputs();
  endtask

  task automatic return_from_trap();
    @(posedge clk);
    op   <= CSR_NONE;
    mret <= 1'b1;
    @(posedge clk);
    quiet_inputs();
  endtask

  // Lines are {ext, sw, timer}
  task automatic set_irq(input logic [2:0] v);
    @(posedge clk);
    op        <= CSR_NONE;
    ext_irq   <= v[2];
    sw_irq    <= v[1];
    timer_irq <= v[0];
  endtask

  task automatic take_exception(input logic [3:0] exc);
    raise_sync(exc, 1'b0, 1'b0);
    cycle_csr(CSR_NONE, CSR_MCAUSE, '0, '0, 1'b0);
    cycle_csr(CSR_NONE, CSR_MEPC, '0, '0, 1'b0);
    return_from_trap();
  endtask

  // Inside the handler an ecall and an mret arrive together, the trap wins
  task automatic exception_with_mret();
    raise_sync(4'b0100, 1'b0, 1'b0);
    @(posedge clk);
    ecall <= 1'b1;
    mret  <= 1'b1;
    @(posedge clk);
    quiet_inputs();
    return_from_trap();
  endtask

  task automatic take_irq(input logic [2:0] v);
    set_irq(v);
    cycle_csr(CSR_NONE, CSR_MIP, '0, '0, 1'b0);
    set_irq(3'b000);
    cycle_csr(CSR_NONE, CSR_MCAUSE, '0, '0, 1'b0);
    return_from_trap();
  endtask

  initial begin
    addr_pool = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
                  CSR_MCAUSE, CSR_MIP, CSR_CYCLE, CSR_CYCLEH,
                  csr_addr_e'(12'h7C0), csr_addr_e'(12'h123)};
    rst_n      <= 1'b0;
    addr       <= CSR_MSTATUS;
    rs1        <= '0;
    imm        <= '0;
    pc         <= '0;
    illegal_pc <= '0;
    ext_irq    <= 1'b0;
    sw_irq     <= 1'b0;
    timer_irq  <= 1'b0;
    quiet_inputs();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values, misa and the running cycle count
    foreach (addr_pool[i]) cycle_csr(CSR_NONE, addr_pool[i], '0, '0, 1'b0);

    repeat (RANDOM_OPS) begin
      cycle_csr(csr_op_e'(3'($unsigned($random(seed)) % 7)),
                addr_pool[4'($unsigned($random(seed)) % 12)],
                $random(seed), $random(seed) & 32'h1F, ($random(seed) & 3) == 0);
    end

    // Synchronous exceptions in direct mode
    cycle_csr(CSR_RW, CSR_MTVEC, 32'h0000_2000, '0, 1'b0);
    return_from_trap();
    take_exception(4'b0001);
    take_exception(4'b0010);
    take_exception(4'b0100);
    take_exception(4'b1000);
    take_exception(4'b1111);
    take_exception(4'b1110);
    exception_with_mret();
    raise_sync(4'b0001, 1'b1, 1'b0);
    raise_sync(4'b0010, 1'b0, 1'b1);

    // Interrupts, direct then vectored, then gated off
    cycle_csr(CSR_RW, CSR_MIE, 32'hFFFF_FFFF, '0, 1'b0);
    cycle_csr(CSR_RSI, CSR_MSTATUS, '0, 32'h8, 1'b0);
    take_irq(3'b111);
    take_irq(3'b011);
    take_irq(3'b001);
    cycle_csr(CSR_RW, CSR_MTVEC, 32'h0000_3001, '0, 1'b0);
    take_irq(3'b100);
    take_irq(3'b001);
    cycle_csr(CSR_RC, CSR_MIE, 32'h0000_0800, '0, 1'b0);
    set_irq(3'b100);
    cycle_csr(CSR_RCI, CSR_MSTATUS, '0, 32'h8, 1'b0);
    set_irq(3'b001);
    set_irq(3'b000);
    repeat (3) cycle_csr(CSR_NONE, CSR_MIP, '0, '0, 1'b0);
    // Let the last driven cycle reach its compare
    @(posedge clk);

    $display("Errors: csr_rd_o %0d, trap_o %0d", word_errs, trap_errs);
    if (word_errs + trap_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/csr_unit_tb_sva.sv
/*
  Assertions bound to the trap FSM: one-cycle redirect
  pulse, idle redirect after reset and exclusive trap
  and mret strobes
*/
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb_sva
  import csr_pkg::*;
(
  input wire        clk,
  input wire        rst_n_i,
  input wire trap_t trap_o,
  input wire        take_trap,
  input wire        do_mret
);

  single_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    trap_o.active |=> !trap_o.active)
    else $error("trap_o.active held for two cycles");

  // First cycle out of reset has no redirect
  reset_idle_a: assert property (@(posedge clk) !rst_n_i |=> !trap_o.active)
    else $error("trap_o.active set right after reset");

  strobe_excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(take_trap && do_mret))
    else $error("take_trap and do_mret high in the same cycle");

endmodule

bind csr_trap_fsm csr_unit_tb_sva csr_unit_tb_sva_i (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .trap_o    (trap_o),
  .take_trap (trap_req),
  .do_mret   (mret_req)
);

`default_nettype wire

// File: hw/csr_unit_top.sv
/*
  CSR unit top level with plain ports: cycle counter,
  trap FSM and CSR register file joined by the trap
  side-band interface
*/
`timescale 1ns/100ps
`default_nettype none

module csr_unit_top
  import csr_pkg::*;
#(
  parameter rdata_t MTVEC_RESET = 32'h0000_1000
)(
  input  wire       clk,
  input  wire       rst_n_i,
  input  wire       stall_i,
  input  csr_op_e   csr_op_i,
  input  csr_addr_e csr_addr_i,
  input  rdata_t    rs1_i,
  input  imm_t      imm_i,
  input  wire       ext_irq_i,
  input  wire       sw_irq_i,
  input  wire       timer_irq_i,
  input  wire       illegal_i,
  input  pc_t       illegal_pc_i,
  input  wire       will_jump_i,
  input  wire       fetch_fault_i,
  input  wire       ecall_i,
  input  wire       ebreak_i,
  input  wire       mret_i,
  input  pc_t       pc_i,
  output rdata_t    csr_rd_o,
  output trap_t     trap_o
);

  cycle_t count;

  csr_trap_if trap_bus ();

  csr_cycle_counter csr_cycle_counter_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .count_o (count)
  );

  csr_trap_fsm csr_trap_fsm_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .ext_irq_i     (ext_irq_i),
    .sw_irq_i      (sw_irq_i),
    .timer_irq_i   (timer_irq_i),
    .illegal_i     (illegal_i),
    .will_jump_i   (will_jump_i),
    .fetch_fault_i (fetch_fault_i),
    .ecall_i       (ecall_i),
    .ebreak_i      (ebreak_i),
    .mret_i        (mret_i),
    .pc_i          (pc_i),
    .illegal_pc_i  (illegal_pc_i),
    .trap_bus      (trap_bus.fsm),
    .trap_o        (trap_o)
  );

  csr_regfile #(
    .MTVEC_RESET (MTVEC_RESET)
  ) csr_regfile_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .csr_op_i    (csr_op_i),
    .csr_addr_i  (csr_addr_i),
    .rs1_i       (rs1_i),
    .imm_i       (imm_i),
    .ext_irq_i   (ext_irq_i),
    .sw_irq_i    (sw_irq_i),
    .timer_irq_i (timer_irq_i),
    .count_i     (count),
    .trap_bus    (trap_bus.regfile),
    .csr_rd_o    (csr_rd_o)
  );

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
/*
  Machine-mode CSR storage: combinational read mux,
  masked read-write / set / clear updates, mip sampling
  and the mstatus, mepc and mcause updates on trap entry
  and mret
*/
`timescale 1ns/100ps
`default_nettype none
`include "csr_defs.svh"

module csr_regfile
  import csr_pkg::*;
#(
  parameter rdata_t MTVEC_RESET = 32'h0000_1000
)(
  input  wire        clk,
  input  wire        rst_n_i,
  input  wire        stall_i,
  input  csr_op_e    csr_op_i,
  input  csr_addr_e  csr_addr_i,
  input  rdata_t     rs1_i,
  input  imm_t       imm_i,
  input  wire        ext_irq_i,
  input  wire        sw_irq_i,
  input  wire        timer_irq_i,
  input  cycle_t     count_i,
  csr_trap_if.regfile trap_bus,
  output rdata_t     csr_rd_o
);

  // MSIE, MTIE and MEIE
  localparam rdata_t MIE_WMASK   = 32'h0000_0888;
  // Bit 1 of mtvec is reserved
  localparam rdata_t MTVEC_WMASK = 32'hFFFF_FFFD;
  localparam rdata_t MEPC_WMASK  = 32'hFFFF_FFFC;

  rdata_t mstatus_q, mstatus_d;
  rdata_t mie_q, mie_d;
  rdata_t mtvec_q, mtvec_d;
  rdata_t mscratch_q, mscratch_d;
  rdata_t mepc_q, mepc_d;
  rdata_t mcause_q, mcause_d;

  logic [IRQ_W-1:0] irq_q;
  rdata_t           mip_word;
  logic             wr_en;

  // Operation result merged into the old value under the write mask
  function automatic rdata_t csr_write(csr_op_e op, rdata_t old_val, rdata_t rs1,
                                       imm_t imm, rdata_t mask);
    rdata_t new_val;

    case (op)
      CSR_RW:  new_val = rs1;
      CSR_RS:  new_val = old_val | rs1;
      CSR_RC:  new_val = old_val & ~rs1;
      CSR_RWI: new_val = imm;
      CSR_RSI: new_val = old_val | imm;
      CSR_RCI: new_val = old_val & ~imm;
      default: new_val = old_val;
    endcase
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  always_comb begin : mip_build
    mip_word                = '0;
    mip_word[`CSR_MIE_MSIE] = irq_q[IRQ_SW_BIT];
    mip_word[`CSR_MIE_MTIE] = irq_q[IRQ_TMR_BIT];
    mip_word[`CSR_MIE_MEIE] = irq_q[IRQ_EXT_BIT];
  end

  // Read side, same cycle as the address
  always_comb begin : rd_mux
    case (csr_addr_i)
      CSR_MSTATUS:  csr_rd_o = mstatus_q;
      CSR_MISA:     csr_rd_o = `CSR_MISA_VAL;
      CSR_MIE:      csr_rd_o = mie_q;
      CSR_MTVEC:    csr_rd_o = mtvec_q;
      CSR_MSCRATCH: csr_rd_o = mscratch_q;
      CSR_MEPC:     csr_rd_o = mepc_q;
      CSR_MCAUSE:   csr_rd_o = mcause_q;
      CSR_MIP:      csr_rd_o = mip_word;
      CSR_CYCLE:    csr_rd_o = count_i[XLEN-1:0];
      CSR_CYCLEH:   csr_rd_o = count_i[CYCLE_W-1:XLEN];
      default:      csr_rd_o = '0;
    endcase
  end

  always_comb begin : wr_next
    wr_en = (csr_op_i != CSR_NONE) && !stall_i && !trap_bus.take_trap;

    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;

    if (wr_en) begin
      case (csr_addr_i)
        CSR_MSTATUS:
          mstatus_d = csr_write(csr_op_i, mstatus_q, rs1_i, imm_i, `CSR_MSTATUS_WMASK);
        CSR_MIE:      mie_d      = csr_write(csr_op_i, mie_q, rs1_i, imm_i, MIE_WMASK);
        CSR_MTVEC:    mtvec_d    = csr_write(csr_op_i, mtvec_q, rs1_i, imm_i, MTVEC_WMASK);
        CSR_MSCRATCH: mscratch_d = csr_write(csr_op_i, mscratch_q, rs1_i, imm_i, '1);
        CSR_MEPC:     mepc_d     = csr_write(csr_op_i, mepc_q, rs1_i, imm_i, MEPC_WMASK);
        default: ;
      endcase
    end

    // Trap side effects override any instruction write
    if (trap_bus.take_trap) begin
      mstatus_d[`CSR_MST_MPIE] = mstatus_q[`CSR_MST_MIE];
      mstatus_d[`CSR_MST_MIE]  = 1'b0;
      mepc_d                   = trap_bus.trap_epc & MEPC_WMASK;
      mcause_d                 = rdata_t'(trap_bus.trap_cause);
    end else if (trap_bus.do_mret) begin
      mstatus_d[`CSR_MST_MIE]  = mstatus_q[`CSR_MST_MPIE];
      mstatus_d[`CSR_MST_MPIE] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RESET;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      irq_q      <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      // mip follows the raw lines one cycle late
      irq_q[IRQ_SW_BIT]  <= sw_irq_i;
      irq_q[IRQ_TMR_BIT] <= timer_irq_i;
      irq_q[IRQ_EXT_BIT] <= ext_irq_i;
    end
  end

  assign trap_bus.mstatus_mie           = mstatus_q[`CSR_MST_MIE];
  assign trap_bus.mie_bits[IRQ_SW_BIT]  = mie_q[`CSR_MIE_MSIE];
  assign trap_bus.mie_bits[IRQ_TMR_BIT] = mie_q[`CSR_MIE_MTIE];
  assign trap_bus.mie_bits[IRQ_EXT_BIT] = mie_q[`CSR_MIE_MEIE];
  assign trap_bus.mtvec                 = mtvec_q;
  assign trap_bus.mepc                  = mepc_q;

endmodule

`default_nettype wire

// File: hw/csr_trap_fsm.sv
/*
  Trap control: interrupt gating, fixed-priority
  trap selection, handler address generation, mret
  handling and the RUN / IN_HANDLER state machine
*/
`timescale 1ns/100ps
`default_nettype none

module csr_trap_fsm
  import csr_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         stall_i,
  input  wire         ext_irq_i,
  input  wire         sw_irq_i,
  input  wire         timer_irq_i,
  input  wire         illegal_i,
  input  wire         will_jump_i,
  input  wire         fetch_fault_i,
  input  wire         ecall_i,
  input  wire         ebreak_i,
  input  wire         mret_i,
  input  pc_t         pc_i,
  input  pc_t         illegal_pc_i,
  csr_trap_if.fsm     trap_bus,
  output trap_t       trap_o
);

  typedef enum logic {
    RUN,
    IN_HANDLER
  } state_e;

  state_e state_q, state_d;
  trap_t  trap_q, trap_d;

  logic   irq_ext, irq_sw, irq_tmr;
  logic   exc_ok;
  logic   trap_req, mret_req;
  cause_e cause;
  pc_t    epc;
  pc_t    base;
  pc_t    vec_off;

  always_comb begin : trap_select
    irq_ext = ext_irq_i   & trap_bus.mstatus_mie & trap_bus.mie_bits[IRQ_EXT_BIT];
    irq_sw  = sw_irq_i    & trap_bus.mstatus_mie & trap_bus.mie_bits[IRQ_SW_BIT];
    irq_tmr = timer_irq_i & trap_bus.mstatus_mie & trap_bus.mie_bits[IRQ_TMR_BIT];

    // Synchronous traps wait for the pipeline to move
    exc_ok   = ~stall_i;
    trap_req = 1'b1;
    cause    = CAUSE_EBREAK;
    epc      = pc_i;

    if (irq_ext) begin
      cause = CAUSE_M_EXT_IRQ;
    end else if (irq_sw) begin
      cause = CAUSE_M_SW_IRQ;
    end else if (irq_tmr) begin
      cause = CAUSE_M_TIMER_IRQ;
    end else if (exc_ok && illegal_i && !will_jump_i) begin
      cause = CAUSE_ILLEGAL;
      epc   = illegal_pc_i;
    end else if (exc_ok && fetch_fault_i) begin
      cause = CAUSE_FETCH_FAULT;
    end else if (exc_ok && ecall_i) begin
      cause = CAUSE_ECALL;
    end else if (exc_ok && ebreak_i) begin
      cause = CAUSE_EBREAK;
    end else begin
      trap_req = 1'b0;
    end

    mret_req = mret_i & exc_ok & (state_q == IN_HANDLER) & ~trap_req;

    // Vectored offset applies to interrupts only, code fits in 4 bits
    base    = {trap_bus.mtvec[XLEN-1:2], 2'b00};
    vec_off = '0;
    if (trap_bus.mtvec[0] && cause[XLEN-1]) begin
      vec_off = {{(XLEN-6){1'b0}}, cause[3:0], 2'b00};
    end

    trap_d = '0;
    if (trap_req) begin
      trap_d.active = 1'b1;
      trap_d.target = base + vec_off;
    end else if (mret_req) begin
      trap_d.active = 1'b1;
      trap_d.target = trap_bus.mepc;
    end

    state_d = state_q;
    if (trap_req) begin
      state_d = IN_HANDLER;
    end else if (mret_req) begin
      state_d = RUN;
    end
  end

  assign trap_bus.take_trap  = trap_req;
  assign trap_bus.trap_cause = cause;
  assign trap_bus.trap_epc   = epc;
  assign trap_bus.do_mret    = mret_req;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RUN;
      trap_q  <= '0;
    end else begin
      state_q <= state_d;
      trap_q  <= trap_d;
    end
  end

  assign trap_o = trap_q;

endmodule

`default_nettype wire

// File: hw/csr_cycle_counter.sv
/*
  Free-running 64-bit cycle counter behind the
  cycle and cycleh CSRs
*/
`timescale 1ns/100ps
`default_nettype none

module csr_cycle_counter
  import csr_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n_i,
  output cycle_t count_o
);

  cycle_t count_q;

  // Wraps silently after 2^64 cycles
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + cycle_t'(1);
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: hw/csr_trap_if.sv
/*
  Trap side-band between the trap FSM and the CSR
  register file: trap entry and mret strobes one way,
  interrupt enables and vector state the other way
*/
`timescale 1ns/100ps
`default_nettype none

interface csr_trap_if import csr_pkg::*; ();

  // Strobes, never high in the same cycle
  logic   take_trap;
  cause_e trap_cause;
  pc_t    trap_epc;
  logic   do_mret;

  // Current CSR state seen by the FSM
  logic             mstatus_mie;
  logic [IRQ_W-1:0] mie_bits;
  rdata_t           mtvec;
  pc_t              mepc;

  modport fsm (
    output take_trap, trap_cause, trap_epc, do_mret,
    input  mstatus_mie, mie_bits, mtvec, mepc
  );

  modport regfile (
    input  take_trap, trap_cause, trap_epc, do_mret,
    output mstatus_mie, mie_bits, mtvec, mepc
  );

endinterface

`default_nettype wire

// File: hw/csr_pkg.sv
/*
  Shared types for the machine-mode CSR unit:
  data, address and counter widths, CSR address and
  operation enums, mcause values, interrupt enable bit
  order and the trap redirect struct
*/
`default_nettype none

package csr_pkg;

  localparam int XLEN    = 32;
  localparam int CYCLE_W = 64;

  typedef logic [XLEN-1:0]    rdata_t;
  typedef logic [XLEN-1:0]    pc_t;
  typedef logic [XLEN-1:0]    imm_t;
  typedef logic [CYCLE_W-1:0] cycle_t;

  // Supported CSR addresses, anything else reads zero
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MIP      = 12'h344,
    CSR_CYCLE    = 12'hC00,
    CSR_CYCLEH   = 12'hC80
  } csr_addr_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd4,
    CSR_RSI  = 3'd5,
    CSR_RCI  = 3'd6
  } csr_op_e;

  // mcause encodings, interrupt flag in the MSB
  typedef enum logic [XLEN-1:0] {
    CAUSE_M_EXT_IRQ   = 32'h8000_000B,
    CAUSE_M_SW_IRQ    = 32'h8000_0003,
    CAUSE_M_TIMER_IRQ = 32'h8000_0007,
    CAUSE_ILLEGAL     = 32'h0000_0002,
    CAUSE_FETCH_FAULT = 32'h0000_0001,
    CAUSE_ECALL       = 32'h0000_000B,
    CAUSE_EBREAK      = 32'h0000_0003
  } cause_e;

  // Order of the three enables carried from mie to the trap FSM
  localparam int IRQ_W       = 3;
  localparam int IRQ_SW_BIT  = 0;
  localparam int IRQ_TMR_BIT = 1;
  localparam int IRQ_EXT_BIT = 2;

  // Redirect request towards fetch
  typedef struct packed {
    logic active;
    pc_t  target;
  } trap_t;

endpackage

`default_nettype wire

// File: include/csr_defs.svh
/*
  Bit positions inside mstatus and mie/mip,
  mstatus write mask and the fixed misa value
*/
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// mstatus fields
`define CSR_MST_MIE  3
`define CSR_MST_MPIE 7

// mie enables, mip uses the same layout
`define CSR_MIE_MSIE 3
`define CSR_MIE_MTIE 7
`define CSR_MIE_MEIE 11

// MXL = 1 (32-bit) and the I extension only
`define CSR_MISA_VAL 32'h4000_0100

// Only MIE and MPIE are implemented
`define CSR_MSTATUS_WMASK 32'h0000_0088

`endif
